// File: core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// First fetch address after reset
`define CORE_RESET_PC      32'h0000_0000

// Data port commands
`define CORE_CMD_NONE      3'd0
`define CORE_CMD_LOAD      3'd1
`define CORE_CMD_STORE     3'd2
// Byte store, only inside the pipe; the port sees STORE with a byte mask
`define CORE_CMD_STORE_B   3'd3

// Major opcodes
`define CORE_OP_REG        7'b0110011
`define CORE_OP_IMM        7'b0010011
`define CORE_OP_LUI        7'b0110111
`define CORE_OP_LOAD       7'b0000011
`define CORE_OP_STORE      7'b0100011
`define CORE_OP_BRANCH     7'b1100011
`define CORE_OP_JAL        7'b1101111

// funct3 / funct7
`define CORE_F3_ADD_SUB    3'b000
`define CORE_F3_SLT        3'b010
`define CORE_F3_XOR        3'b100
`define CORE_F3_OR         3'b110
`define CORE_F3_AND        3'b111
`define CORE_F3_BEQ        3'b000
`define CORE_F3_BNE        3'b001
`define CORE_F3_LW         3'b010
`define CORE_F3_SB         3'b000
`define CORE_F3_SW         3'b010
`define CORE_F7_ADD        7'b0000000
`define CORE_F7_SUB        7'b0100000

`endif

// File: core_pkg.sv
package core_pkg;

	// *******************************************************************
	// Instruction formats
	// *******************************************************************

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One word, six views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JAL
	} br_kind_e;

	// *******************************************************************
	// Stage bundles and port requests
	// *******************************************************************

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		inst_u       inst;
	} id_bundle_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		alu_op_e     alu_op;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] rs2_data;
		logic [31:0] imm;
		br_kind_e    br_kind;
		logic [2:0]  mem_cmd;
		logic [4:0]  rd;
		logic        rf_wen;
	} ex_bundle_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] alu_out;
		logic [31:0] rs2_data;
		logic [2:0]  mem_cmd;
		logic [4:0]  rd;
		logic        rf_wen;
	} mem_bundle_t;

	typedef struct packed {
		logic        wen;
		logic [4:0]  addr;
		logic [31:0] data;
	} wb_t;

	typedef struct packed {
		logic        start;
		logic [31:0] addr;
	} imem_req_t;

	typedef struct packed {
		logic [2:0]  cmd;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] wmask;
	} dmem_req_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_stage import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        stall_i,
	input  logic        redirect_valid_i,
	input  logic [31:0] redirect_pc_i,
	output imem_req_t   imem_req_o,
	input  logic        inst_ready_i,
	input  logic [31:0] inst_i,
	input  logic        inst_valid_i,
	output id_bundle_t  id_o
);

	typedef enum logic [1:0] {
		F_IDLE,
		F_REQ,
		F_WAIT
	} fetch_state_e;

	fetch_state_e state_q;
	logic [31:0]  pc_q;
	logic         drop_q;
	logic         word_arrives;
	logic         slot_free;

	// Data may come back in the same cycle as ready
	assign word_arrives = inst_valid_i &&
		((state_q == F_WAIT) || ((state_q == F_REQ) && inst_ready_i));

	// Decode slot is empty after this edge, so a new word has a place to land
	assign slot_free = !id_o.valid || !stall_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= F_IDLE;
			pc_q       <= `CORE_RESET_PC;
			drop_q     <= 1'b0;
			imem_req_o <= '0;
			id_o       <= '0;
		end else begin
			// Decode slot
			if (redirect_valid_i) begin
				id_o.valid <= 1'b0;
			end else if (word_arrives && !drop_q) begin
				id_o.valid <= 1'b1;
				id_o.pc    <= pc_q;
				id_o.inst  <= inst_i;
			end else if (!stall_i) begin
				id_o.valid <= 1'b0;
			end

			// PC
			if (redirect_valid_i) begin
				pc_q <= redirect_pc_i;
			end else if (word_arrives && !drop_q) begin
				pc_q <= pc_q + 32'd4;
			end

			// Squashed fetch still in flight
			if (redirect_valid_i && (state_q != F_IDLE) && !word_arrives) begin
				drop_q <= 1'b1;
			end else if (word_arrives) begin
				drop_q <= 1'b0;
			end

			case (state_q)
				F_IDLE: begin
					if (!redirect_valid_i && slot_free) begin
						imem_req_o.start <= 1'b1;
						imem_req_o.addr  <= pc_q;
						state_q          <= F_REQ;
					end
				end
				F_REQ: begin
					if (inst_ready_i) begin
						imem_req_o.start <= 1'b0;
						state_q          <= word_arrives ? F_IDLE : F_WAIT;
					end
				end
				F_WAIT: begin
					if (inst_valid_i) begin
						state_q <= F_IDLE;
					end
				end
				default: state_q <= F_IDLE;
			endcase
		end
	end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic [4:0]  rs1_addr_i,
	input  logic [4:0]  rs2_addr_i,
	output logic [31:0] rs1_data_o,
	output logic [31:0] rs2_data_o,
	input  wb_t         wb_i
);

	logic [31:0] regs [32];

	// x0 is hardwired to zero
	assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'd0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'd0 : regs[rs2_addr_i];

	// No write-through; decode holds until the writer has left memory
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wb_i.wen && (wb_i.addr != 5'd0)) begin
			regs[wb_i.addr] <= wb_i.data;
		end
	end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_stage import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        stall_i,
	input  logic        flush_i,
	input  id_bundle_t  id_i,
	output logic [4:0]  rs1_addr_o,
	output logic [4:0]  rs2_addr_o,
	input  logic [31:0] rs1_data_i,
	input  logic [31:0] rs2_data_i,
	input  logic [4:0]  ex_busy_rd_i,
	input  logic        ex_busy_wen_i,
	input  wb_t         wb_busy_i,
	output logic        hold_o,
	output ex_bundle_t  ex_o
);

	inst_u       inst;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic        use_rs1;
	logic        use_rs2;
	logic        hazard_rs1;
	logic        hazard_rs2;
	ex_bundle_t  ex_next;

	assign inst       = id_i.inst;
	assign rs1_addr_o = inst.r_fmt.rs1;
	assign rs2_addr_o = inst.r_fmt.rs2;

	// Sign-extended immediates, one per format
	assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
	assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
	assign imm_b = {{20{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
		inst.b_fmt.imm4_1, 1'b0};
	assign imm_u = {inst.u_fmt.imm, 12'd0};
	assign imm_j = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
		inst.j_fmt.imm10_1, 1'b0};

	always_comb begin
		ex_next          = '0;
		ex_next.valid    = id_i.valid;
		ex_next.pc       = id_i.pc;
		ex_next.alu_op   = ALU_ADD;
		ex_next.op1      = rs1_data_i;
		ex_next.op2      = rs2_data_i;
		ex_next.rs2_data = rs2_data_i;
		ex_next.br_kind  = BR_NONE;
		ex_next.mem_cmd  = `CORE_CMD_NONE;
		ex_next.rd       = inst.r_fmt.rd;
		use_rs1          = 1'b0;
		use_rs2          = 1'b0;
		case (inst.r_fmt.opcode)
			`CORE_OP_REG: begin
				use_rs1        = 1'b1;
				use_rs2        = 1'b1;
				ex_next.rf_wen = 1'b1;
				case (inst.r_fmt.funct3)
					`CORE_F3_ADD_SUB: ex_next.alu_op =
						(inst.r_fmt.funct7 == `CORE_F7_SUB) ? ALU_SUB : ALU_ADD;
					`CORE_F3_SLT: ex_next.alu_op = ALU_SLT;
					`CORE_F3_XOR: ex_next.alu_op = ALU_XOR;
					`CORE_F3_OR:  ex_next.alu_op = ALU_OR;
					`CORE_F3_AND: ex_next.alu_op = ALU_AND;
					default:      ex_next.alu_op = ALU_ADD;
				endcase
			end
			`CORE_OP_IMM, `CORE_OP_LOAD: begin
				use_rs1        = 1'b1;
				ex_next.op2    = imm_i;
				ex_next.imm    = imm_i;
				ex_next.rf_wen = 1'b1;
				if (inst.r_fmt.opcode == `CORE_OP_LOAD) begin
					ex_next.mem_cmd = `CORE_CMD_LOAD;
				end
			end
			`CORE_OP_LUI: begin
				ex_next.alu_op = ALU_PASS_B;
				ex_next.op2    = imm_u;
				ex_next.imm    = imm_u;
				ex_next.rf_wen = 1'b1;
			end
			`CORE_OP_STORE: begin
				use_rs1         = 1'b1;
				use_rs2         = 1'b1;
				ex_next.op2     = imm_s;
				ex_next.imm     = imm_s;
				ex_next.mem_cmd = (inst.s_fmt.funct3 == `CORE_F3_SB) ?
					`CORE_CMD_STORE_B : `CORE_CMD_STORE;
			end
			`CORE_OP_BRANCH: begin
				use_rs1     = 1'b1;
				use_rs2     = 1'b1;
				ex_next.imm = imm_b;
				if (inst.b_fmt.funct3 == `CORE_F3_BEQ) begin
					ex_next.br_kind = BR_EQ;
				end else if (inst.b_fmt.funct3 == `CORE_F3_BNE) begin
					ex_next.br_kind = BR_NE;
				end
			end
			`CORE_OP_JAL: begin
				// Link value pc+4 comes out of the ALU
				ex_next.op1     = id_i.pc;
				ex_next.op2     = 32'd4;
				ex_next.imm     = imm_j;
				ex_next.br_kind = BR_JAL;
				ex_next.rf_wen  = 1'b1;
			end
			default: ex_next.valid = 1'b0;
		endcase
	end

	// Interlock against writers still in execute or memory
	assign hazard_rs1 = use_rs1 && (rs1_addr_o != 5'd0) &&
		((ex_busy_wen_i && (ex_busy_rd_i == rs1_addr_o)) ||
		(wb_busy_i.wen && (wb_busy_i.addr == rs1_addr_o)));
	assign hazard_rs2 = use_rs2 && (rs2_addr_o != 5'd0) &&
		((ex_busy_wen_i && (ex_busy_rd_i == rs2_addr_o)) ||
		(wb_busy_i.wen && (wb_busy_i.addr == rs2_addr_o)));
	assign hold_o = id_i.valid && (hazard_rs1 || hazard_rs2);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_o <= '0;
		end else if (flush_i) begin
			ex_o.valid <= 1'b0;
		end else if (!stall_i) begin
			if (hold_o) begin
				ex_o.valid <= 1'b0;
			end else begin
				ex_o <= ex_next;
			end
		end
	end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        stall_i,
	input  ex_bundle_t  ex_i,
	output logic        redirect_valid_o,
	output logic [31:0] redirect_pc_o,
	output mem_bundle_t mem_o
);

	logic [31:0] alu_out;
	logic        taken;

	// *******************************************************************
	// ALU
	// *******************************************************************

	always_comb begin
		case (ex_i.alu_op)
			ALU_ADD:    alu_out = ex_i.op1 + ex_i.op2;
			ALU_SUB:    alu_out = ex_i.op1 - ex_i.op2;
			ALU_AND:    alu_out = ex_i.op1 & ex_i.op2;
			ALU_OR:     alu_out = ex_i.op1 | ex_i.op2;
			ALU_XOR:    alu_out = ex_i.op1 ^ ex_i.op2;
			ALU_SLT:    alu_out = {31'd0, $signed(ex_i.op1) < $signed(ex_i.op2)};
			ALU_PASS_B: alu_out = ex_i.op2;
			default:    alu_out = ex_i.op1 + ex_i.op2;
		endcase
	end

	// *******************************************************************
	// Branch resolution
	// *******************************************************************

	always_comb begin
		case (ex_i.br_kind)
			BR_EQ:   taken = (ex_i.op1 == ex_i.rs2_data);
			BR_NE:   taken = (ex_i.op1 != ex_i.rs2_data);
			BR_JAL:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// Fires once, on the cycle the branch leaves for memory
	assign redirect_valid_o = ex_i.valid && taken && !stall_i;
	assign redirect_pc_o    = ex_i.pc + ex_i.imm;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_o <= '0;
		end else if (!stall_i) begin
			mem_o.valid    <= ex_i.valid;
			mem_o.alu_out  <= alu_out;
			mem_o.rs2_data <= ex_i.rs2_data;
			mem_o.mem_cmd  <= ex_i.mem_cmd;
			mem_o.rd       <= ex_i.rd;
			mem_o.rf_wen   <= ex_i.rf_wen;
		end
	end

endmodule

// File: memory_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module memory_stage import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  mem_bundle_t mem_i,
	output dmem_req_t   dmem_req_o,
	input  logic        d_cmd_ready_i,
	input  logic [31:0] rdata_i,
	input  logic        rdata_valid_i,
	output logic        stall_o,
	output wb_t         wb_o
);

	logic       is_load;
	logic       is_store;
	logic       is_byte;
	logic       accepted_q;
	logic       done;
	logic [4:0] shamt;

	assign is_byte  = (mem_i.mem_cmd == `CORE_CMD_STORE_B);
	assign is_load  = mem_i.valid && (mem_i.mem_cmd == `CORE_CMD_LOAD);
	assign is_store = mem_i.valid && ((mem_i.mem_cmd == `CORE_CMD_STORE) || is_byte);

	// Byte lane within the word
	assign shamt = {mem_i.alu_out[1:0], 3'b000};

	// *******************************************************************
	// Data port request
	// *******************************************************************

	always_comb begin
		dmem_req_o.cmd   = `CORE_CMD_NONE;
		dmem_req_o.addr  = mem_i.alu_out;
		dmem_req_o.wdata = mem_i.rs2_data;
		dmem_req_o.wmask = 32'hFFFF_FFFF;
		if (is_byte) begin
			dmem_req_o.wdata = {24'd0, mem_i.rs2_data[7:0]} << shamt;
			dmem_req_o.wmask = 32'h0000_00FF << shamt;
		end
		if (is_store) begin
			dmem_req_o.cmd = `CORE_CMD_STORE;
		end else if (is_load && !accepted_q) begin
			dmem_req_o.cmd = `CORE_CMD_LOAD;
		end
	end

	// Load command taken, data not back yet
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			accepted_q <= 1'b0;
		end else if (!is_load || rdata_valid_i) begin
			accepted_q <= 1'b0;
		end else if (d_cmd_ready_i) begin
			accepted_q <= 1'b1;
		end
	end

	// *******************************************************************
	// Completion and write-back
	// *******************************************************************

	always_comb begin
		if (is_store) begin
			done = d_cmd_ready_i;
		end else if (is_load) begin
			done = rdata_valid_i && (accepted_q || d_cmd_ready_i);
		end else begin
			done = 1'b1;
		end
	end

	assign stall_o = (is_load || is_store) && !done;

	assign wb_o.wen  = mem_i.valid && mem_i.rf_wen && done;
	assign wb_o.addr = mem_i.rd;
	assign wb_o.data = is_load ? rdata_i : mem_i.alu_out;

endmodule

// File: core.sv
`timescale 1ns/1ps

module core import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	output imem_req_t   imem_req_o,
	input  logic        inst_ready_i,
	input  logic [31:0] inst_i,
	input  logic        inst_valid_i,
	output dmem_req_t   dmem_req_o,
	input  logic        d_cmd_ready_i,
	input  logic [31:0] rdata_i,
	input  logic        rdata_valid_i
);

	logic        mem_stall;
	logic        dec_hold;
	logic        fetch_stall;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	id_bundle_t  id_bundle;
	ex_bundle_t  ex_bundle;
	mem_bundle_t mem_bundle;
	wb_t         wb;
	wb_t         mem_busy;

	assign fetch_stall = mem_stall | dec_hold;

	// Destination of the instruction sitting in memory, pending or not
	assign mem_busy.wen  = mem_bundle.valid && mem_bundle.rf_wen;
	assign mem_busy.addr = mem_bundle.rd;
	assign mem_busy.data = mem_bundle.alu_out;

	// *******************************************************************
	// Fetch and decode
	// *******************************************************************

	fetch_stage u_fetch (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.stall_i          (fetch_stall),
		.redirect_valid_i (redirect_valid),
		.redirect_pc_i    (redirect_pc),
		.imem_req_o       (imem_req_o),
		.inst_ready_i     (inst_ready_i),
		.inst_i           (inst_i),
		.inst_valid_i     (inst_valid_i),
		.id_o             (id_bundle)
	);

	register_file u_regfile (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wb_i       (wb)
	);

	decode_stage u_decode (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.stall_i       (mem_stall),
		.flush_i       (redirect_valid),
		.id_i          (id_bundle),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.ex_busy_rd_i  (ex_bundle.rd),
		.ex_busy_wen_i (ex_bundle.valid && ex_bundle.rf_wen),
		.wb_busy_i     (mem_busy),
		.hold_o        (dec_hold),
		.ex_o          (ex_bundle)
	);

	// *******************************************************************
	// Execute and memory
	// *******************************************************************

	execute_stage u_execute (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.stall_i          (mem_stall),
		.ex_i             (ex_bundle),
		.redirect_valid_o (redirect_valid),
		.redirect_pc_o    (redirect_pc),
		.mem_o            (mem_bundle)
	);

	memory_stage u_memory (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.mem_i         (mem_bundle),
		.dmem_req_o    (dmem_req_o),
		.d_cmd_ready_i (d_cmd_ready_i),
		.rdata_i       (rdata_i),
		.rdata_valid_i (rdata_valid_i),
		.stall_o       (mem_stall),
		.wb_o          (wb)
	);

endmodule

// File: core_sva.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core_sva import core_pkg::*; (
	input logic      clk,
	input logic      rst_n_i,
	input imem_req_t imem_req_i,
	input logic      inst_ready_i,
	input dmem_req_t dmem_req_i,
	input logic      d_cmd_ready_i
);

	// Instruction request held until ready
	imem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		imem_req_i.start && !inst_ready_i |=> imem_req_i.start && $stable(imem_req_i.addr))
		else $error("instruction request changed before ready");

	// Data command held until ready
	dmem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(dmem_req_i.cmd != `CORE_CMD_NONE) && !d_cmd_ready_i |=> $stable(dmem_req_i))
		else $error("data request changed before ready");

	// Quiet ports in reset
	reset_state: assert property (@(posedge clk)
		!rst_n_i |-> !imem_req_i.start && (dmem_req_i.cmd == `CORE_CMD_NONE))
		else $error("port request active during reset");

endmodule

// File: tb_core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_core import core_pkg::*; ();

	localparam int CLK_PERIOD    = 4;
	localparam int PROGRAM_WORDS = 160;
	localparam int MAX_DELAY     = 8;
	localparam int WATCHDOG_NS   = PROGRAM_WORDS * 40 * MAX_DELAY * CLK_PERIOD;

	logic        clk;
	logic        rst_n;
	imem_req_t   imem_req;
	logic        inst_ready;
	logic [31:0] inst_word;
	logic        inst_valid;
	dmem_req_t   dmem_req;
	logic        d_cmd_ready;
	logic [31:0] rdata;
	logic        rdata_valid;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] prog [$];
	dmem_req_t   exp_stores [$];
	logic        ibp;
	logic        dbp;

	core dut0 (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.imem_req_o    (imem_req),
		.inst_ready_i  (inst_ready),
		.inst_i        (inst_word),
		.inst_valid_i  (inst_valid),
		.dmem_req_o    (dmem_req),
		.d_cmd_ready_i (d_cmd_ready),
		.rdata_i       (rdata),
		.rdata_valid_i (rdata_valid)
	);

	bind core core_sva u_sva (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.imem_req_i    (imem_req_o),
		.inst_ready_i  (inst_ready_i),
		.dmem_req_i    (dmem_req_o),
		.d_cmd_ready_i (d_cmd_ready_i)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// *******************************************************************
	// Reporting and compare tasks
	// *******************************************************************

	task automatic fail_run(input string why);
		if (why != "") begin
			$display("%s", why);
		end
		$display("Regression failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("error: time %0t, %s is %h, expected %h", $time, name, got, exp);
		fail_run("");
	endtask

	task automatic compare_store(input dmem_req_t got, input dmem_req_t exp);
		if (got.addr !== exp.addr) begin
			report_mismatch("dmem_req_o.addr", got.addr, exp.addr);
		end
		if (got.wdata !== exp.wdata) begin
			report_mismatch("dmem_req_o.wdata", got.wdata, exp.wdata);
		end
		if (got.wmask !== exp.wmask) begin
			report_mismatch("dmem_req_o.wmask", got.wmask, exp.wmask);
		end
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			report_mismatch(name, got, exp);
		end
	endtask

	// *******************************************************************
	// Program assembly
	// *******************************************************************

	task automatic addi(input int rd, input int rs1, input int imm);
		prog.push_back({imm[11:0], rs1[4:0], `CORE_F3_ADD_SUB, rd[4:0], `CORE_OP_IMM});
	endtask

	task automatic lui(input int rd, input int hi);
		prog.push_back({hi[19:0], rd[4:0], `CORE_OP_LUI});
	endtask

	task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input int rd,
		input int rs1, input int rs2);
		prog.push_back({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `CORE_OP_REG});
	endtask

	task automatic lw(input int rd, input int rs1, input int imm);
		prog.push_back({imm[11:0], rs1[4:0], `CORE_F3_LW, rd[4:0], `CORE_OP_LOAD});
	endtask

	task automatic store(input logic [2:0] f3, input int rs2, input int rs1, input int imm);
		prog.push_back({imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `CORE_OP_STORE});
	endtask

	task automatic branch(input logic [2:0] f3, input int rs1, input int rs2, input int imm);
		prog.push_back({imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
			`CORE_OP_BRANCH});
	endtask

	task automatic jal(input int rd, input int imm);
		prog.push_back({imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `CORE_OP_JAL});
	endtask

	task automatic pad(input int gap);
		repeat (gap) addi(0, 0, 0);
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [31:0] wmask);
		dmem_req_t req;
		req.cmd   = `CORE_CMD_STORE;
		req.addr  = addr;
		req.wdata = wdata;
		req.wmask = wmask;
		exp_stores.push_back(req);
	endtask

	// *******************************************************************
	// Test sequencing
	// *******************************************************************

	task automatic begin_test(input logic inst_bp, input logic data_bp);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		ibp   = inst_bp;
		dbp   = data_bp;
		prog.delete();
		exp_stores.delete();
		// Fill depends on every address bit
		for (int i = 0; i < 256; i++) begin
			dmem[i] = 32'(i * 4) ^ 32'hA5A5_0000;
		end
	endtask

	task automatic run_program;
		// Self loop parks the core once the program is done
		jal(0, 0);
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : prog[prog.size() - 1];
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		while (exp_stores.size() != 0) begin
			@(posedge clk);
		end
		// Room for any stray store to show up
		repeat (20) @(posedge clk);
	endtask

	task automatic alu_and_store(input logic [6:0] f7, input logic [2:0] f3, input int rd,
		input int rs1, input int rs2, input int offset, input int gap);
		reg_op(f7, f3, rd, rs1, rs2);
		pad(gap);
		store(`CORE_F3_SW, rd, 10, offset);
		pad(gap);
	endtask

	task automatic alu_ops(input int gap, input logic bp);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] vals [7];
		a = 32'd100;
		b = 32'h1234_5678;
		c = -32'sd7;
		vals = '{a + c, a - c, b & a, b | a, b ^ c,
			{31'd0, $signed(c) < $signed(a)}, {31'd0, $signed(a) < $signed(c)}};
		begin_test(bp, bp);
		addi(1, 0, 100);
		lui(2, 32'h12345);
		addi(2, 2, 32'h678);
		addi(3, 0, -7);
		addi(10, 0, 32'h200);
		pad(gap);
		alu_and_store(`CORE_F7_ADD, `CORE_F3_ADD_SUB, 4, 1, 3, 0, gap);
		alu_and_store(`CORE_F7_SUB, `CORE_F3_ADD_SUB, 5, 1, 3, 4, gap);
		alu_and_store(`CORE_F7_ADD, `CORE_F3_AND, 6, 2, 1, 8, gap);
		alu_and_store(`CORE_F7_ADD, `CORE_F3_OR, 7, 2, 1, 12, gap);
		alu_and_store(`CORE_F7_ADD, `CORE_F3_XOR, 8, 2, 3, 16, gap);
		alu_and_store(`CORE_F7_ADD, `CORE_F3_SLT, 9, 3, 1, 20, gap);
		alu_and_store(`CORE_F7_ADD, `CORE_F3_SLT, 11, 1, 3, 24, gap);
		for (int i = 0; i < 7; i++) begin
			expect_store(32'h200 + 32'(i * 4), vals[i], 32'hFFFF_FFFF);
		end
		run_program();
		for (int i = 0; i < 7; i++) begin
			compare_word($sformatf("dmem[%0d]", 128 + i), dmem[128 + i], vals[i]);
		end
	endtask

	task automatic load_use;
		logic [31:0] w0;
		logic [31:0] w1;
		w0 = 32'h0000_1111;
		w1 = 32'h2222_0000;
		begin_test(1'b0, 1'b1);
		dmem[192] = w0;
		dmem[193] = w1;
		addi(20, 0, 32'h300);
		lw(1, 20, 0);
		lw(2, 20, 4);
		reg_op(`CORE_F7_ADD, `CORE_F3_ADD_SUB, 3, 1, 2);
		store(`CORE_F3_SW, 3, 20, 8);
		reg_op(`CORE_F7_SUB, `CORE_F3_ADD_SUB, 4, 2, 1);
		store(`CORE_F3_SW, 4, 20, 12);
		expect_store(32'h308, w0 + w1, 32'hFFFF_FFFF);
		expect_store(32'h30C, w1 - w0, 32'hFFFF_FFFF);
		run_program();
		compare_word("dmem[194]", dmem[194], w0 + w1);
		compare_word("dmem[195]", dmem[195], w1 - w0);
	endtask

	task automatic byte_stores;
		logic [31:0] value;
		begin_test(1'b0, 1'b0);
		dmem[145] = 32'hA5A5_A5A5;
		addi(10, 0, 32'h240);
		for (int k = 0; k < 4; k++) begin
			value = 32'h100 + 32'(32'h11 * (k + 1));
			addi(1, 0, int'(value));
			store(`CORE_F3_SB, 1, 10, k);
			// The byte sits in the lane picked by the low address bits
			expect_store(32'h240 + 32'(k), {4{value[7:0]}} & (32'h0000_00FF << (8 * k)),
				32'h0000_00FF << (8 * k));
		end
		addi(1, 0, 32'h77);
		store(`CORE_F3_SB, 1, 10, 5);
		expect_store(32'h245, 32'h0000_7700, 32'h0000_FF00);
		run_program();
		compare_word("dmem[144]", dmem[144], 32'h4433_2211);
		compare_word("dmem[145]", dmem[145], 32'hA5A5_77A5);
	endtask

	task automatic control_flow;
		begin_test(1'b0, 1'b0);
		addi(1, 0, 5);
		addi(2, 0, 5);
		addi(10, 0, 32'h280);
		branch(`CORE_F3_BEQ, 1, 2, 12);
		store(`CORE_F3_SW, 1, 10, 0);
		store(`CORE_F3_SW, 1, 10, 0);
		branch(`CORE_F3_BNE, 1, 2, 12);
		store(`CORE_F3_SW, 2, 10, 4);
		branch(`CORE_F3_BNE, 1, 0, 12);
		store(`CORE_F3_SW, 1, 10, 8);
		store(`CORE_F3_SW, 1, 10, 8);
		branch(`CORE_F3_BEQ, 1, 0, 8);
		store(`CORE_F3_SW, 1, 10, 12);
		jal(5, 12);
		store(`CORE_F3_SW, 1, 10, 16);
		store(`CORE_F3_SW, 1, 10, 16);
		store(`CORE_F3_SW, 5, 10, 20);
		expect_store(32'h284, 32'd5, 32'hFFFF_FFFF);
		expect_store(32'h28C, 32'd5, 32'hFFFF_FFFF);
		// Link register holds the address after the JAL at 52
		expect_store(32'h294, 32'd56, 32'hFFFF_FFFF);
		run_program();
		compare_word("dmem[165]", dmem[165], 32'd56);
	endtask

	// *******************************************************************
	// Memory models
	// *******************************************************************

	initial begin : inst_model
		logic        took;
		logic [31:0] addr;
		forever begin
			@(negedge clk);
			took = rst_n && imem_req.start && inst_ready;
			addr = imem_req.addr;
			@(posedge clk);
			#1;
			inst_valid = 1'b0;
			if (took) begin
				inst_word  = imem[addr[9:2]];
				inst_valid = 1'b1;
				inst_ready = 1'b0;
			end else begin
				inst_ready = ibp ? ($urandom % 3 == 0) : 1'b1;
			end
		end
	end

	task automatic commit_store(input dmem_req_t req);
		if (exp_stores.size() == 0) begin
			fail_run($sformatf("unexpected store to address %h at time %0t", req.addr, $time));
		end
		compare_store(req, exp_stores.pop_front());
		dmem[req.addr[9:2]] = (dmem[req.addr[9:2]] & ~req.wmask) | (req.wdata & req.wmask);
	endtask

	initial begin : data_model
		dmem_req_t req;
		int        delay;
		forever begin
			@(posedge clk);
			#1;
			if (rst_n && (dmem_req.cmd != `CORE_CMD_NONE)) begin
				req   = dmem_req;
				delay = dbp ? int'($urandom % MAX_DELAY) : int'($urandom % 4);
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				d_cmd_ready = 1'b1;
				@(posedge clk);
				if (req.cmd == `CORE_CMD_STORE) begin
					commit_store(req);
				end
				#1;
				d_cmd_ready = 1'b0;
				if (req.cmd == `CORE_CMD_LOAD) begin
					delay = int'($urandom % 3);
					repeat (delay) begin
						@(posedge clk);
						#1;
					end
					rdata       = dmem[req.addr[9:2]];
					rdata_valid = 1'b1;
					@(posedge clk);
					#1;
					rdata_valid = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		fail_run("watchdog timeout, the core stopped making progress");
	end

	initial begin
		void'($urandom(81164));
		rst_n       = 1'b0;
		inst_ready  = 1'b0;
		inst_word   = 32'd0;
		inst_valid  = 1'b0;
		d_cmd_ready = 1'b0;
		rdata       = 32'd0;
		rdata_valid = 1'b0;
		ibp         = 1'b0;
		dbp         = 1'b0;
		alu_ops(3, 1'b0);
		// Same program back to back leans on the interlock
		alu_ops(0, 1'b0);
		load_use();
		byte_stores();
		control_flow();
		alu_ops(0, 1'b1);
		$display("Regression passed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
core_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core.sv
core_sva.sv
tb_core.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_core -f filelist.f -Mdir obj_dir \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_core > sim.log 2>&1
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
